//--- Makefile
TOP := tb_ram18

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f build.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns \
		-f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- build.f
src/ram18_pkg.sv
src/ram18_write_lane.sv
src/ram18_array.sv
src/ram18_read_lane.sv
src/ram18_var_w_var_r.sv
verification/tb_clock_gen.sv
verification/tb_ram18.sv

//--- src/ram18_array.sv
`timescale 1ns/1ns

module ram18_array (
   input  logic                  wclk_i,         // Write clock
   input  logic                  rclk_i,         // Read clock
   input  logic                  arst_n_i,       // Async reset for the read latch
   input  logic                  wr_en_i,        // Write strobe
   input  ram18_pkg::word_addr_t wr_word_addr_i, // Word being written
   input  ram18_pkg::word_t      wr_mask_i,      // Bits that take new data
   input  ram18_pkg::word_t      wr_data_i,      // Data already placed in the word
   input  logic                  rd_en_i,        // Read strobe
   input  ram18_pkg::word_addr_t rd_word_addr_i, // Word being read
   output ram18_pkg::word_t      rd_word_o       // Latched read word
);

   localparam int depth = 1 << ram18_pkg::word_addr_bits;          // 512 words

   ram18_pkg::word_t mem [depth];                                   // Storage, contents not reset
   ram18_pkg::word_t wr_merged;                                     // Old word with new bits merged
   ram18_pkg::word_t rd_latch;                                      // Read port latch

   // Read-modify-write merge, only masked bits change
   assign wr_merged = (mem[wr_word_addr_i] & ~wr_mask_i) | (wr_data_i & wr_mask_i);

   always_ff @(posedge wclk_i) begin
      if (wr_en_i) begin
         mem[wr_word_addr_i] <= wr_merged;                          // Stored at this edge
      end
   end

   // Read side latches the whole word; the lane picks the sub-word later
   always_ff @(posedge rclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_latch <= '0;                                            // Zero until first read
      end else if (rd_en_i) begin
         rd_latch <= mem[rd_word_addr_i];                           // Hold while rd_en_i low
      end
   end

   assign rd_word_o = rd_latch;

endmodule

//--- src/ram18_pkg.sv
package ram18_pkg;

   // Physical organization of the half block RAM, 512 x 32 = 16 Kbit
   localparam int word_bits      = 32;  // Bits per storage word
   localparam int word_addr_bits = 9;   // 512 words
   localparam int bit_addr_bits  = 14;  // Full bit address as the vendor block counts it
   localparam int lanes          = 4;   // Byte lanes per word
   localparam int max_log2width  = 5;   // Widest port is 2**5 = 32 bits

   // One storage word, bit 0 is the least significant
   typedef logic [word_bits-1:0] word_t;

   // Word address, the upper 9 bits of any port address
   typedef logic [word_addr_bits-1:0] word_addr_t;

   // Byte write enables, bit i covers bits 8*i+7 down to 8*i
   typedef logic [lanes-1:0] lane_en_t;

   // Sub-word index inside a word, counted in units of the port width
   // A 1-bit port needs all 5 bits, a 32-bit port none
   typedef logic [max_log2width-1:0] offset_t;

endpackage

//--- src/ram18_read_lane.sv
`timescale 1ns/1ns

module ram18_read_lane #(
   parameter int log2width_rd = 5,                                   // Read width is 2**log2width_rd
   parameter int registers    = 0                                    // 1 adds the output register
) (
   input  logic                                              rclk_i,         // Read clock
   input  logic                                              arst_n_i,       // Async reset
   input  logic [ram18_pkg::bit_addr_bits-1-log2width_rd:0] raddr_i,        // Port address
   input  logic                                              ren_i,          // Read enable
   input  logic                                              regen_i,        // Output reg enable
   input  ram18_pkg::word_t                                  rd_word_i,      // Latched word
   output logic                                              rd_en_o,        // Read strobe
   output ram18_pkg::word_addr_t                             rd_word_addr_o, // Word to latch
   output logic [(1 << log2width_rd)-1:0]                    data_out_o      // Port data
);

   localparam int port_bits = 1 << log2width_rd;                     // Port width in bits
   localparam int off_bits  = ram18_pkg::max_log2width - log2width_rd; // Offset field width

   ram18_pkg::offset_t       rd_offset;                              // Offset of the latched read
   logic [port_bits-1:0]     sub_word;                               // Selected slice of the word

   assign rd_en_o = ren_i;                                           // Array latches on ren_i
   // Upper address bits select the word
   assign rd_word_addr_o = raddr_i[ram18_pkg::bit_addr_bits-1-log2width_rd -:
                                   ram18_pkg::word_addr_bits];

   generate
      if (log2width_rd < ram18_pkg::max_log2width) begin : g_offset
         // Offset travels with the word, so it is captured on the same edge
         always_ff @(posedge rclk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
               rd_offset <= '0;
            end else if (ren_i) begin
               rd_offset <= ram18_pkg::offset_t'(raddr_i[off_bits-1:0]); // Hold while ren_i low
            end
         end
      end else begin : g_no_offset
         assign rd_offset = '0;                                      // Full word read
      end
   endgenerate

   assign sub_word = rd_word_i[rd_offset * port_bits +: port_bits];  // Sub-word 0 is the LSBs

   generate
      if (registers != 0) begin : g_out_reg
         logic [port_bits-1:0] out_q;                                // Output pipeline stage

         always_ff @(posedge rclk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
               out_q <= '0;
            end else if (regen_i) begin
               out_q <= sub_word;                                    // One edge after the latch
            end
         end
         assign data_out_o = out_q;
      end else begin : g_out_comb
         assign data_out_o = sub_word;                               // Straight from the latch
      end
   endgenerate

   // An X on the address would latch an unknown word and offset
   ap_raddr_known : assert property (
      @(posedge rclk_i) disable iff (!arst_n_i) ren_i |-> !$isunknown(raddr_i)
   ) else $error("ram18_read_lane: raddr_i has unknown bits during a read");

endmodule

//--- src/ram18_var_w_var_r.sv
`timescale 1ns/1ns

module ram18_var_w_var_r #(
   parameter int log2width_wr = 5,                                   // Write width is 2**log2width_wr
   parameter int log2width_rd = 5,                                   // Read width is 2**log2width_rd
   parameter int registers    = 0                                    // 1 adds the output register
) (
   input  logic                                              rclk_i,     // Read clock
   input  logic                                              wclk_i,     // Write clock
   input  logic                                              arst_n_i,   // Async reset, active low
   input  logic [ram18_pkg::bit_addr_bits-1-log2width_rd:0] raddr_i,    // Read address
   input  logic                                              ren_i,      // Read enable
   input  logic                                              regen_i,    // Output reg enable
   output logic [(1 << log2width_rd)-1:0]                    data_out_o, // Read data
   input  logic [ram18_pkg::bit_addr_bits-1-log2width_wr:0] waddr_i,    // Write address
   input  logic                                              we_i,       // Write enable
   input  ram18_pkg::lane_en_t                               web_i,      // Byte enables, 32-bit only
   input  logic [(1 << log2width_wr)-1:0]                    data_in_i   // Write data
);

   logic                  wr_en;                                     // Write strobe to the array
   ram18_pkg::word_addr_t wr_word_addr;                              // Write word address
   ram18_pkg::word_t      wr_mask;                                   // Write bit mask
   ram18_pkg::word_t      wr_data;                                   // Placed write data
   logic                  rd_en;                                     // Read strobe to the array
   ram18_pkg::word_addr_t rd_word_addr;                              // Read word address
   ram18_pkg::word_t      rd_word;                                   // Latched read word

   // Port widths of 1 to 32 bits only
   if (log2width_wr < 0 || log2width_wr > ram18_pkg::max_log2width) begin : g_bad_wr
      $error("ram18_var_w_var_r: log2width_wr=%0d outside 0..%0d",
             log2width_wr, ram18_pkg::max_log2width);
   end
   if (log2width_rd < 0 || log2width_rd > ram18_pkg::max_log2width) begin : g_bad_rd
      $error("ram18_var_w_var_r: log2width_rd=%0d outside 0..%0d",
             log2width_rd, ram18_pkg::max_log2width);
   end
   if (registers != 0 && registers != 1) begin : g_bad_reg
      $error("ram18_var_w_var_r: registers=%0d must be 0 or 1", registers);
   end

   ram18_write_lane #(
      .log2width_wr   (log2width_wr)
   ) u_write_lane (
      .wclk_i         (wclk_i),
      .waddr_i        (waddr_i),
      .we_i           (we_i),
      .web_i          (web_i),
      .data_in_i      (data_in_i),
      .wr_en_o        (wr_en),
      .wr_word_addr_o (wr_word_addr),
      .wr_mask_o      (wr_mask),
      .wr_data_o      (wr_data)
   );

   ram18_array u_array (
      .wclk_i         (wclk_i),
      .rclk_i         (rclk_i),
      .arst_n_i       (arst_n_i),
      .wr_en_i        (wr_en),
      .wr_word_addr_i (wr_word_addr),
      .wr_mask_i      (wr_mask),
      .wr_data_i      (wr_data),
      .rd_en_i        (rd_en),
      .rd_word_addr_i (rd_word_addr),
      .rd_word_o      (rd_word)
   );

   ram18_read_lane #(
      .log2width_rd   (log2width_rd),
      .registers      (registers)
   ) u_read_lane (
      .rclk_i         (rclk_i),
      .arst_n_i       (arst_n_i),
      .raddr_i        (raddr_i),
      .ren_i          (ren_i),
      .regen_i        (regen_i),
      .rd_word_i      (rd_word),
      .rd_en_o        (rd_en),
      .rd_word_addr_o (rd_word_addr),
      .data_out_o     (data_out_o)
   );

endmodule

//--- src/ram18_write_lane.sv
`timescale 1ns/1ns

module ram18_write_lane #(
   parameter int log2width_wr = 5                                    // Write width is 2**log2width_wr
) (
   input  logic                                              wclk_i,         // Write clock
   input  logic [ram18_pkg::bit_addr_bits-1-log2width_wr:0] waddr_i,        // Port address
   input  logic                                              we_i,           // Write request
   input  ram18_pkg::lane_en_t                               web_i,          // Byte enables
   input  logic [(1 << log2width_wr)-1:0]                    data_in_i,      // Port data
   output logic                                              wr_en_o,        // Write strobe
   output ram18_pkg::word_addr_t                             wr_word_addr_o, // Target word
   output ram18_pkg::word_t                                  wr_mask_o,      // Bits to update
   output ram18_pkg::word_t                                  wr_data_o       // Data in position
);

   localparam int port_bits = 1 << log2width_wr;                     // Port width in bits
   localparam int off_bits  = ram18_pkg::max_log2width - log2width_wr; // Offset field width

   ram18_pkg::offset_t wr_offset;                                    // Sub-word index

   assign wr_en_o = we_i;                                            // No write pipeline
   // Upper address bits select the word
   assign wr_word_addr_o = waddr_i[ram18_pkg::bit_addr_bits-1-log2width_wr -:
                                   ram18_pkg::word_addr_bits];

   generate
      if (log2width_wr == ram18_pkg::max_log2width) begin : g_full
         localparam int lane_bits = ram18_pkg::word_bits / ram18_pkg::lanes; // 8 bits

         ram18_pkg::word_t lane_mask;                                // Bytes picked by web_i

         assign wr_offset = '0;                                      // Whole word, no offset
         always_comb begin
            for (int i = 0; i < ram18_pkg::lanes; i++) begin
               lane_mask[i*lane_bits +: lane_bits] = {lane_bits{web_i[i]}}; // Spread lane bit
            end
         end
         assign wr_mask_o = lane_mask;
      end else begin : g_narrow
         // Low address bits pick the sub-word, web_i has no say here
         assign wr_offset = ram18_pkg::offset_t'(waddr_i[off_bits-1:0]);
         assign wr_mask_o = ram18_pkg::word_t'({port_bits{1'b1}}) << (wr_offset * port_bits);
      end
   endgenerate

   // Sub-word 0 sits at the least significant bits
   assign wr_data_o = ram18_pkg::word_t'(data_in_i) << (wr_offset * port_bits);

   // An X on the address while writing would corrupt an unknown word
   ap_waddr_known : assert property (
      @(posedge wclk_i) we_i |-> !$isunknown(waddr_i)
   ) else $error("ram18_write_lane: waddr_i has unknown bits during a write");

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int period       = 100,  // Clock period in ns
   parameter int reset_cycles = 2     // Rising edges seen with reset low
) (
   output logic clk_o,                // Shared read and write clock
   output logic arst_n_o              // Active low reset
);

   always begin
      clk_o = 1'b0;                   // Starts low, first rise at period/2
      #(period / 2);
      clk_o = 1'b1;
      #(period / 2);
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (reset_cycles) @(posedge clk_o);
      @(negedge clk_o);               // Release away from the active edge
      arst_n_o = 1'b1;
   end

endmodule

//--- verification/tb_ram18.sv
`timescale 1ns/1ns

module tb_ram18;

   logic        clk;                  // One clock for both ports
   logic        arst_n;
   logic [11:0] raddr;                // dut: 4-bit read port
   logic        ren;
   logic        regen;
   logic [3:0]  dout;
   logic [8:0]  waddr;                // dut: 32-bit write port
   logic        we;
   logic [3:0]  web;
   logic [31:0] din;
   logic [8:0]  nw_raddr;             // dut_nw: 32-bit read port
   logic        nw_ren;
   logic [31:0] nw_dout;
   logic [12:0] nw_waddr;             // dut_nw: 2-bit write port
   logic        nw_we;
   logic [1:0]  nw_din;
   integer      seed;                 // State of $random
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   logic        reset_ok;
   logic [3:0]  last_nib;             // Value the dut output register holds now
   logic [31:0] ref_mem [512];        // Expected words behind dut
   logic [31:0] ref_nw [512];         // Expected words behind dut_nw
   logic [8:0]  test_addr [4];        // Words exercised by the tests

   tb_clock_gen #(.period(100), .reset_cycles(2)) u_clock_gen (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   ram18_var_w_var_r #(
      .log2width_wr (5),
      .log2width_rd (2),
      .registers    (1)
   ) dut (
      .rclk_i     (clk),
      .wclk_i     (clk),
      .arst_n_i   (arst_n),
      .raddr_i    (raddr),
      .ren_i      (ren),
      .regen_i    (regen),
      .data_out_o (dout),
      .waddr_i    (waddr),
      .we_i       (we),
      .web_i      (web),
      .data_in_i  (din)
   );

   ram18_var_w_var_r #(
      .log2width_wr (1),
      .log2width_rd (5),
      .registers    (0)
   ) dut_nw (
      .rclk_i     (clk),
      .wclk_i     (clk),
      .arst_n_i   (arst_n),
      .raddr_i    (nw_raddr),
      .ren_i      (nw_ren),
      .regen_i    (1'b0),             // No output register here
      .data_out_o (nw_dout),
      .waddr_i    (nw_waddr),
      .we_i       (nw_we),
      .web_i      (4'h0),             // Ignored below 32 bits
      .data_in_i  (nw_din)
   );

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic wait_reset_release(output logic ok);
      int cycles;
      cycles = 0;
      while (arst_n !== 1'b1 && cycles < 20) begin
         @(posedge clk);
         cycles++;
      end
      ok = (arst_n === 1'b1);
      if (!ok) begin
         $display("Reset was still asserted after %0d cycles", cycles);
      end
   endtask

   // Full width write through dut, byte lanes from be
   task automatic write_word(input logic [8:0] a, input logic [31:0] data,
                             input logic [3:0] be);
      logic [31:0] mask;
      for (int i = 0; i < 4; i++) begin
         mask[8*i +: 8] = {8{be[i]}};
      end
      waddr = a;
      din   = data;
      web   = be;
      we    = 1'b1;
      @(negedge clk);                 // Stored at the rising edge in between
      we = 1'b0;
      ref_mem[a] = (ref_mem[a] & ~mask) | (data & mask);
   endtask

   // One nibble read, old value after 1 cycle, new one after 2
   task automatic read_nibble(input logic [8:0] a, input int k);
      logic [3:0] exp;
      exp   = ref_mem[a][4*k +: 4];
      raddr = {a, k[2:0]};
      ren   = 1'b1;
      regen = 1'b1;
      @(negedge clk);
      ren = 1'b0;
      check_value("dut.data_out_o", {28'd0, dout}, {28'd0, last_nib});
      @(negedge clk);
      check_value("dut.data_out_o", {28'd0, dout}, {28'd0, exp});
      last_nib = exp;
   endtask

   task automatic test_reset();
      int e0;
      e0 = errors;
      check_value("dut.data_out_o", {28'd0, dout}, 32'd0);
      check_value("dut_nw.data_out_o", nw_dout, 32'd0);
      finish_test("reset", e0);
   endtask

   task automatic test_full_write();
      int e0;
      e0 = errors;
      for (int i = 0; i < 4; i++) begin
         write_word(test_addr[i], $random(seed), 4'hF);
      end
      for (int i = 0; i < 4; i++) begin
         for (int k = 0; k < 8; k++) begin
            read_nibble(test_addr[i], k);  // Nibble k counts from the LSBs
         end
      end
      finish_test("full word write", e0);
   endtask

   task automatic test_byte_enables();
      int e0;
      e0 = errors;
      write_word(test_addr[1], $random(seed), 4'b0101);
      for (int k = 0; k < 8; k++) begin
         read_nibble(test_addr[1], k);
      end
      write_word(test_addr[2], $random(seed), 4'b1000);
      for (int k = 0; k < 8; k++) begin
         read_nibble(test_addr[2], k);
      end
      finish_test("byte enables", e0);
   endtask

   task automatic test_enables_hold();
      int         e0;
      int         k_new;
      logic [3:0] v_old;
      logic [3:0] v_new;
      e0 = errors;
      read_nibble(test_addr[0], 0);
      v_old = last_nib;
      k_new = 1;
      for (int k = 7; k >= 1; k--) begin
         if (ref_mem[test_addr[3]][4*k +: 4] != v_old) begin
            k_new = k;                // Prefer a nibble that shows the change
         end
      end
      v_new = ref_mem[test_addr[3]][4*k_new +: 4];
      raddr = {test_addr[3], k_new[2:0]};  // Must not reach the latch while ren is low
      regen = 1'b1;                   // ren low, latch and offset hold
      for (int c = 0; c < 3; c++) begin
         @(negedge clk);
         check_value("dut.data_out_o", {28'd0, dout}, {28'd0, v_old});
      end
      ren   = 1'b1;
      @(negedge clk);
      ren   = 1'b0;
      regen = 1'b0;                   // New word latched but not passed on
      check_value("dut.data_out_o", {28'd0, dout}, {28'd0, v_old});
      for (int c = 0; c < 2; c++) begin
         @(negedge clk);
         check_value("dut.data_out_o", {28'd0, dout}, {28'd0, v_old});
      end
      regen = 1'b1;
      @(negedge clk);
      check_value("dut.data_out_o", {28'd0, dout}, {28'd0, v_new});
      last_nib = v_new;
      finish_test("enables hold", e0);
   endtask

   task automatic test_narrow_write();
      int          e0;
      logic [31:0] w;
      e0 = errors;
      for (int i = 0; i < 3; i++) begin
         w = $random(seed);
         for (int k = 0; k < 16; k++) begin
            nw_waddr = {test_addr[i], k[3:0]};  // Piece k lands at bits 2k+1..2k
            nw_din   = w[2*k +: 2];
            nw_we    = 1'b1;
            @(negedge clk);
            ref_nw[test_addr[i]][2*k +: 2] = w[2*k +: 2];
         end
         nw_we = 1'b0;
      end
      for (int i = 0; i < 3; i++) begin
         nw_raddr = test_addr[i];
         nw_ren   = 1'b1;
         @(negedge clk);
         nw_ren = 1'b0;
         check_value("dut_nw.data_out_o", nw_dout, ref_nw[test_addr[i]]);
      end
      finish_test("narrow write", e0);
   endtask

   task automatic test_back_to_back();
      int         e0;
      int         k;
      logic [8:0] a;
      logic [3:0] exp;
      logic [3:0] exp_q [6];
      e0 = errors;
      regen = 1'b1;
      for (int c = 0; c < 7; c++) begin
         if (c < 6) begin
            a        = test_addr[c % 4];
            k        = $random(seed) & 7;
            exp_q[c] = ref_mem[a][4*k +: 4];
            raddr    = {a, k[2:0]};
            ren      = 1'b1;
         end else begin
            ren = 1'b0;
         end
         @(negedge clk);
         if (c == 0) begin
            exp = last_nib;           // Still the last single read
         end else begin
            exp = exp_q[c-1];         // Read issued one cycle earlier
         end
         check_value("dut.data_out_o", {28'd0, dout}, {28'd0, exp});
      end
      last_nib = exp_q[5];
      finish_test("back-to-back reads", e0);
   endtask

   initial begin
      seed         = 44054;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      raddr        = '0;
      ren          = 1'b0;
      regen        = 1'b0;
      waddr        = '0;
      we           = 1'b0;
      web          = '0;
      din          = '0;
      nw_raddr     = '0;
      nw_ren       = 1'b0;
      nw_waddr     = '0;
      nw_we        = 1'b0;
      nw_din       = '0;
      last_nib     = '0;              // Output register is zero out of reset
      test_addr[0] = 9'd5;
      test_addr[1] = 9'd130;
      test_addr[2] = 9'd257;
      test_addr[3] = 9'd511;
      wait_reset_release(reset_ok);
      if (!reset_ok) begin
         $display("RESULT: FAIL");
         $finish;
      end else begin
         @(negedge clk);
         test_reset();
         test_full_write();
         test_byte_enables();
         test_enables_hold();
         test_narrow_write();
         test_back_to_back();
         $display("tests %0d, failed %0d, checks %0d, errors %0d",
                  tests_run, tests_failed, checks, errors);
         if (errors == 0) begin
            $display("RESULT: PASS");
         end else begin
            $display("RESULT: FAIL");
         end
         $finish;
      end
   end

endmodule
